// ==== verilog/aemb_pkg.sv ====
`default_nettype none

package aemb_pkg;

   // Major opcode field, bits [31:26] of the instruction word
   // Values follow the octal layout of the ISA tables
   typedef enum logic [5:0] {
      // Group 2 ALU ops, only MUL and BSF are implemented
      MUL   = 6'o20,
      BSF   = 6'o21,
      // Divide has no hardware here and traps as illegal
      DIV   = 6'o22,
      // FSL get/put, immediate bit 15 selects direction
      FSL   = 6'o33,
      // Unconditional branch, register and immediate forms
      BRU   = 6'o46,
      BRUI  = 6'o56,
      // Representative load and store encodings
      LOAD  = 6'o60,
      STORE = 6'o64
   } opc_e;

   // Decoded operation class handed to the strobe and interrupt logic
   typedef enum logic [2:0] {
      OPC_ALU     = 3'd0,
      OPC_LOAD    = 3'd1,
      OPC_STORE   = 3'd2,
      OPC_GET     = 3'd3,
      OPC_PUT     = 3'd4,
      OPC_INTACK  = 3'd5,
      OPC_XCEACK  = 3'd6,
      OPC_ILLEGAL = 3'd7
   } op_class_e;

   // Machine status register bits, bit 3 reserved
   localparam int MSR_BE  = 0;
   localparam int MSR_IE  = 1;
   localparam int MSR_BIP = 2;

   // BRUI with these RA values acts as an acknowledge
   localparam logic [4:0] RA_INTACK = 5'h0D;
   localparam logic [4:0] RA_XCEACK = 5'h0F;

   // Status flags above the register bits in the readback word
   localparam int STAT_INT = 4;
   localparam int STAT_XCE = 5;

endpackage

`default_nettype wire

// ==== verilog/aemb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded operation from the operand-fetch stage
interface dec_if import aemb_pkg::*; ();

   // Class of the presented op while accepting, else last accepted class
   op_class_e opclass;
   // Valid and ready together
   logic      acc;
   // Accept-qualified one-cycle pulses
   logic      ill;
   logic      intack;
   logic      xceack;

   // Decoder side
   modport src (
      output opclass,
      output acc,
      output ill,
      output intack,
      output xceack
   );

   // Strobe and interrupt side
   modport sink (
      input  opclass,
      input  acc,
      input  ill,
      input  intack,
      input  xceack
   );

endinterface

// Status register bits out, pending flags back
interface msr_if ();

   logic ie;
   logic be;
   logic bip;
   // Pending interrupt and exception
   logic irq;
   logic xce;

   modport regs (output ie, be, bip, input irq, xce);
   modport intr (input ie, bip, output irq, xce);

endinterface

`default_nettype wire

// ==== verilog/aemb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_decode import aemb_pkg::*; (
   input  logic        clk_o,
   input  logic        rst_o,
   input  logic        op_valid_i,
   input  logic        op_ready_i,
   input  opc_e        op_opc_i,
   input  logic [4:0]  op_ra_i,
   input  logic [15:0] op_imm_i,
   dec_if.src          dec
);

   logic [5:0] opc;
   logic       is_ldst;
   logic       is_fsl;
   logic       is_brui;
   logic       ill_raw;
   op_class_e  cls_now;
   op_class_e  cls_q;

   // Raw bit view of the opcode for field tests
   assign opc = op_opc_i;

   // Loads and stores share the 6x/7x octal range
   assign is_ldst = (opc[5:4] == 2'b11);
   assign is_fsl  = (op_opc_i == FSL);
   assign is_brui = (op_opc_i == BRUI);

   // Illegal opcode catcher
   // Size field 3 on load/store does not exist
   // Group 3 holds only the FSL opcode
   // Group 2 is MUL/BSF only, DIV and the rest trap
   assign ill_raw = (is_ldst && (opc[1:0] == 2'b11))
                  || ((opc[5:3] == 3'o3) && !is_fsl)
                  || ((opc[5:3] == 3'o2) && (opc[2:1] != 2'b00));

   // Class of the operation being presented
   always_comb begin
      cls_now = OPC_ALU;
      if (ill_raw) begin
         cls_now = OPC_ILLEGAL;
      end else if (is_ldst) begin
         // Bit 2 splits store from load
         cls_now = opc[2] ? OPC_STORE : OPC_LOAD;
      end else if (is_fsl) begin
         // RB[4] lands in immediate bit 15
         cls_now = op_imm_i[15] ? OPC_PUT : OPC_GET;
      end else if (is_brui && (op_ra_i == RA_INTACK)) begin
         cls_now = OPC_INTACK;
      end else if (is_brui && (op_ra_i == RA_XCEACK)) begin
         cls_now = OPC_XCEACK;
      end
   end

   // Handshake completes this cycle
   assign dec.acc = op_valid_i & op_ready_i;

   // Last accepted class, held between operations
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         cls_q <= OPC_ALU;
      end else if (dec.acc) begin
         cls_q <= cls_now;
      end
   end

   assign dec.opclass = dec.acc ? cls_now : cls_q;

   // Flags only pulse on accepted ops
   assign dec.ill    = dec.acc & (cls_now == OPC_ILLEGAL);
   assign dec.intack = dec.acc & (cls_now == OPC_INTACK);
   assign dec.xceack = dec.acc & (cls_now == OPC_XCEACK);

endmodule

`default_nettype wire

// ==== verilog/aemb_sysc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_sysc_ctrl (
   input  logic sys_clk_i,
   input  logic sys_rst_i,
   input  logic iwb_stb_i,
   input  logic iwb_ack_i,
   input  logic dwb_stb_i,
   input  logic dwb_ack_i,
   input  logic cwb_stb_i,
   input  logic cwb_ack_i,
   output logic clk_o,
   output logic rst_o,
   output logic pha_o,
   output logic ena_o
);

   // No clock manager, core runs on the board clock
   assign clk_o = sys_clk_i;

   // Pipeline moves only when every bus is settled
   // Any strobe/ack mismatch is an outstanding transfer
   assign ena_o = ~((iwb_stb_i ^ iwb_ack_i)
                  | (dwb_stb_i ^ dwb_ack_i)
                  | (cwb_stb_i ^ cwb_ack_i));

   // Phase starts at 1 and flips each enabled cycle
   // Core reset drops once the phase has gone low
   always_ff @(posedge clk_o) begin
      if (sys_rst_i) begin
         pha_o <= 1'b1;
         rst_o <= 1'b1;
      end else begin
         if (ena_o) begin
            pha_o <= ~pha_o;
         end
         // Second edge after release
         if (!pha_o) begin
            rst_o <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/aemb_msr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_msr_regs import aemb_pkg::*; (
   input  logic       clk_o,
   input  logic       rst_o,
   input  logic       cfg_we_i,
   input  logic [3:0] cfg_wdata_i,
   output logic [5:0] cfg_rdata_o,
   msr_if.regs        msr
);

   logic ie_q;
   logic be_q;
   logic bip_q;

   // Status bits, written whole from the config port
   // Reserved bit 3 is not stored
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         ie_q  <= 1'b0;
         be_q  <= 1'b0;
         bip_q <= 1'b0;
      end else if (cfg_we_i) begin
         ie_q  <= cfg_wdata_i[MSR_IE];
         be_q  <= cfg_wdata_i[MSR_BE];
         bip_q <= cfg_wdata_i[MSR_BIP];
      end
   end

   // Steering bits for interrupt and bus lock
   assign msr.ie  = ie_q;
   assign msr.be  = be_q;
   assign msr.bip = bip_q;

   // Readback word
   // Low nibble is the register, reserved reads 0
   // Pending flags sit above it
   always_comb begin
      cfg_rdata_o           = '0;
      cfg_rdata_o[MSR_IE]   = ie_q;
      cfg_rdata_o[MSR_BE]   = be_q;
      cfg_rdata_o[MSR_BIP]  = bip_q;
      cfg_rdata_o[STAT_INT] = msr.irq;
      cfg_rdata_o[STAT_XCE] = msr.xce;
   end

endmodule

`default_nettype wire

// ==== verilog/aemb_intr.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_intr (
   input  logic clk_o,
   input  logic rst_o,
   input  logic sys_int_i,
   dec_if.sink  dec,
   msr_if.intr  msr,
   output logic int_o,
   output logic xce_o
);

   logic irq_q;
   logic xce_q;
   logic int_arm;

   // Interrupts taken only when enabled and no break is running
   assign int_arm = msr.ie & ~msr.bip;

   // Level interrupt latch
   // An intack in the same cycle wins over a new request
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         irq_q <= 1'b0;
      end else if (dec.intack) begin
         irq_q <= 1'b0;
      end else if (int_arm && sys_int_i) begin
         irq_q <= 1'b1;
      end
   end

   // Hardware exception on an accepted illegal opcode
   // Held until software acks it
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         xce_q <= 1'b0;
      end else if (dec.xceack) begin
         xce_q <= 1'b0;
      end else if (dec.ill) begin
         xce_q <= 1'b1;
      end
   end

   // Flags out to the pins and back to the readback word
   assign int_o   = irq_q;
   assign xce_o   = xce_q;
   assign msr.irq = irq_q;
   assign msr.xce = xce_q;

endmodule

`default_nettype wire

// ==== verilog/aemb_bus_strobe.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_bus_strobe import aemb_pkg::*; #(
   parameter int TXE = 1
) (
   input  logic clk_o,
   input  logic rst_o,
   input  logic pha_i,
   input  logic ena_i,
   input  logic op_valid_i,
   output logic op_ready_o,
   dec_if.sink  dec,
   input  logic be_i,
   input  logic iwb_ack_i,
   input  logic dwb_ack_i,
   input  logic cwb_ack_i,
   output logic iwb_stb_o,
   output logic iwb_wre_o,
   output logic dwb_cyc_o,
   output logic dwb_stb_o,
   output logic dwb_wre_o,
   output logic cwb_stb_o,
   output logic cwb_wre_o
);

   logic take;
   logic take_ls;
   logic take_fsl;

   // Ready only with the pipe enabled and no data/FSL transfer open
   assign op_ready_o = ~rst_o & ena_i & ~dwb_stb_o & ~cwb_stb_o;

   // Operation accepted this cycle
   assign take     = op_valid_i & op_ready_o;
   assign take_ls  = take & ((dec.opclass == OPC_LOAD) | (dec.opclass == OPC_STORE));
   assign take_fsl = take & ((dec.opclass == OPC_GET) | (dec.opclass == OPC_PUT));

   // Data bus
   // Strobe held until the ack edge, write flag rides along
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         dwb_stb_o <= 1'b0;
         dwb_wre_o <= 1'b0;
      end else if (dwb_stb_o && dwb_ack_i) begin
         dwb_stb_o <= 1'b0;
         dwb_wre_o <= 1'b0;
      end else if (take_ls) begin
         dwb_stb_o <= 1'b1;
         dwb_wre_o <= (dec.opclass == OPC_STORE);
      end
   end

   // FSL bus, put drives the write flag
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         cwb_stb_o <= 1'b0;
         cwb_wre_o <= 1'b0;
      end else if (cwb_stb_o && cwb_ack_i) begin
         cwb_stb_o <= 1'b0;
         cwb_wre_o <= 1'b0;
      end else if (take_fsl) begin
         cwb_stb_o <= 1'b1;
         cwb_wre_o <= (dec.opclass == OPC_PUT);
      end
   end

   // Instruction fetch
   // Single thread fetches every cycle, otherwise only in phase 1
   always_ff @(posedge clk_o) begin
      if (rst_o) begin
         iwb_stb_o <= 1'b0;
      end else if (iwb_stb_o && iwb_ack_i) begin
         iwb_stb_o <= 1'b0;
      end else if (!iwb_stb_o) begin
         iwb_stb_o <= (TXE != 0) | pha_i;
      end
   end

   // Fetch is read only
   assign iwb_wre_o = 1'b0;

   // Bus lock keeps the data cycle open between strobes
   assign dwb_cyc_o = dwb_stb_o | be_i;

endmodule

`default_nettype wire

// ==== verilog/aemb_sysc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_sysc_top import aemb_pkg::*; #(
   parameter int TXE = 1
) (
   input  logic        sys_clk_i,
   input  logic        sys_rst_i,
   input  logic        sys_int_i,
   // Operation from operand fetch
   input  logic        op_valid_i,
   output logic        op_ready_o,
   input  logic [5:0]  op_opc_i,
   input  logic [4:0]  op_ra_i,
   input  logic [15:0] op_imm_i,
   // Status register access
   input  logic        cfg_we_i,
   input  logic [3:0]  cfg_wdata_i,
   output logic [5:0]  cfg_rdata_o,
   // Bus strobes
   output logic        iwb_stb_o,
   output logic        iwb_wre_o,
   output logic        dwb_cyc_o,
   output logic        dwb_stb_o,
   output logic        dwb_wre_o,
   output logic        cwb_stb_o,
   output logic        cwb_wre_o,
   // Bus acknowledges
   input  logic        iwb_ack_i,
   input  logic        dwb_ack_i,
   input  logic        cwb_ack_i,
   // Status
   output logic        int_o,
   output logic        xce_o,
   output logic        clk_o,
   output logic        rst_o,
   output logic        ena_o,
   output logic        pha_o
);

   dec_if dec_i ();
   msr_if msr_i ();

   // Clock, reset stretch, phase and enable
   aemb_sysc_ctrl u_ctrl (
      .sys_clk_i (sys_clk_i),
      .sys_rst_i (sys_rst_i),
      .iwb_stb_i (iwb_stb_o),
      .iwb_ack_i (iwb_ack_i),
      .dwb_stb_i (dwb_stb_o),
      .dwb_ack_i (dwb_ack_i),
      .cwb_stb_i (cwb_stb_o),
      .cwb_ack_i (cwb_ack_i),
      .clk_o     (clk_o),
      .rst_o     (rst_o),
      .pha_o     (pha_o),
      .ena_o     (ena_o)
   );

   // Partial opcode decode
   aemb_decode u_decode (
      .clk_o      (clk_o),
      .rst_o      (rst_o),
      .op_valid_i (op_valid_i),
      .op_ready_i (op_ready_o),
      .op_opc_i   (opc_e'(op_opc_i)),
      .op_ra_i    (op_ra_i),
      .op_imm_i   (op_imm_i),
      .dec        (dec_i)
   );

   aemb_msr_regs u_msr (
      .clk_o       (clk_o),
      .rst_o       (rst_o),
      .cfg_we_i    (cfg_we_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .msr         (msr_i)
   );

   aemb_intr u_intr (
      .clk_o     (clk_o),
      .rst_o     (rst_o),
      .sys_int_i (sys_int_i),
      .dec       (dec_i),
      .msr       (msr_i),
      .int_o     (int_o),
      .xce_o     (xce_o)
   );

   // Strobes and operation ready
   aemb_bus_strobe #(
      .TXE (TXE)
   ) u_strobe (
      .clk_o      (clk_o),
      .rst_o      (rst_o),
      .pha_i      (pha_o),
      .ena_i      (ena_o),
      .op_valid_i (op_valid_i),
      .op_ready_o (op_ready_o),
      .dec        (dec_i),
      .be_i       (msr_i.be),
      .iwb_ack_i  (iwb_ack_i),
      .dwb_ack_i  (dwb_ack_i),
      .cwb_ack_i  (cwb_ack_i),
      .iwb_stb_o  (iwb_stb_o),
      .iwb_wre_o  (iwb_wre_o),
      .dwb_cyc_o  (dwb_cyc_o),
      .dwb_stb_o  (dwb_stb_o),
      .dwb_wre_o  (dwb_wre_o),
      .cwb_stb_o  (cwb_stb_o),
      .cwb_wre_o  (cwb_wre_o)
   );

endmodule

`default_nettype wire

// ==== sim/aemb_sysc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module aemb_sysc_checker (
   input logic clk_i,
   input logic rst_i,
   input logic op_ready_i,
   input logic iwb_stb_i,
   input logic iwb_ack_i,
   input logic iwb_wre_i,
   input logic dwb_stb_i,
   input logic dwb_ack_i,
   input logic cwb_stb_i,
   input logic cwb_ack_i
);

   // Count of failed assertions
   int unsigned fail_cnt = 0;

   // A raised strobe holds until the edge that samples its ack
   a_iwb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (iwb_stb_i && !iwb_ack_i) |=> iwb_stb_i)
      else begin
         $error("iwb strobe dropped before its ack");
         fail_cnt++;
      end
   a_dwb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (dwb_stb_i && !dwb_ack_i) |=> dwb_stb_i)
      else begin
         $error("dwb strobe dropped before its ack");
         fail_cnt++;
      end
   a_cwb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (cwb_stb_i && !cwb_ack_i) |=> cwb_stb_i)
      else begin
         $error("cwb strobe dropped before its ack");
         fail_cnt++;
      end

   // No new operation while a data or FSL transfer is open
   a_ready_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      (dwb_stb_i || cwb_stb_i) |-> !op_ready_i)
      else begin
         $error("op_ready_o high with a data or FSL strobe set");
         fail_cnt++;
      end

   // Fetch bus is read only
   a_iwb_read: assert property (@(posedge clk_i) !iwb_wre_i)
      else begin
         $error("iwb_wre_o went high");
         fail_cnt++;
      end

endmodule

bind aemb_bus_strobe aemb_sysc_checker chk0 (
   .clk_i      (clk_o),
   .rst_i      (rst_o),
   .op_ready_i (op_ready_o),
   .iwb_stb_i  (iwb_stb_o),
   .iwb_ack_i  (iwb_ack_i),
   .iwb_wre_i  (iwb_wre_o),
   .dwb_stb_i  (dwb_stb_o),
   .dwb_ack_i  (dwb_ack_i),
   .cwb_stb_i  (cwb_stb_o),
   .cwb_ack_i  (cwb_ack_i)
);

`default_nettype wire

// ==== sim/aemb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Slave model that acks a strobe after 0 to 3 cycles
module ack_responder (
   input  logic clk_i,
   input  logic rst_i,
   input  logic hold_i,
   input  logic stb_i,
   output logic ack_o
);

   int unsigned wait_q;

   initial ack_o = 1'b0;

   // Ack lasts one cycle and drops on the edge that takes it
   always @(posedge clk_i) begin
      if (rst_i || ack_o) begin
         ack_o  <= 1'b0;
         wait_q <= $urandom % 4;
      end else if (stb_i && !hold_i) begin
         if (wait_q == 0) begin
            ack_o <= 1'b1;
         end else begin
            wait_q <= wait_q - 1;
         end
      end
   end

endmodule

module aemb_tb import aemb_pkg::*; ();

   localparam int TMO = 64;

   logic        sys_clk_i;
   logic        sys_rst_i;
   logic        sys_int_i;
   logic        op_valid_i;
   logic        op_ready_o;
   logic [5:0]  op_opc_i;
   logic [4:0]  op_ra_i;
   logic [15:0] op_imm_i;
   logic        cfg_we_i;
   logic [3:0]  cfg_wdata_i;
   logic [5:0]  cfg_rdata_o;
   logic        iwb_stb_o;
   logic        iwb_wre_o;
   logic        dwb_cyc_o;
   logic        dwb_stb_o;
   logic        dwb_wre_o;
   logic        cwb_stb_o;
   logic        cwb_wre_o;
   logic        iwb_ack_i;
   logic        dwb_ack_i;
   logic        cwb_ack_i;
   logic        int_o;
   logic        xce_o;
   logic        clk_o;
   logic        rst_o;
   logic        ena_o;
   logic        pha_o;
   // Testbench state
   logic        hold_ack;
   logic        lock_exp;
   logic        pha_exp;
   logic        ena_ref;
   logic        mon_on;

   aemb_sysc_top #(
      .TXE (1)
   ) dut0 (
      .sys_clk_i   (sys_clk_i),
      .sys_rst_i   (sys_rst_i),
      .sys_int_i   (sys_int_i),
      .op_valid_i  (op_valid_i),
      .op_ready_o  (op_ready_o),
      .op_opc_i    (op_opc_i),
      .op_ra_i     (op_ra_i),
      .op_imm_i    (op_imm_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .iwb_stb_o   (iwb_stb_o),
      .iwb_wre_o   (iwb_wre_o),
      .dwb_cyc_o   (dwb_cyc_o),
      .dwb_stb_o   (dwb_stb_o),
      .dwb_wre_o   (dwb_wre_o),
      .cwb_stb_o   (cwb_stb_o),
      .cwb_wre_o   (cwb_wre_o),
      .iwb_ack_i   (iwb_ack_i),
      .dwb_ack_i   (dwb_ack_i),
      .cwb_ack_i   (cwb_ack_i),
      .int_o       (int_o),
      .xce_o       (xce_o),
      .clk_o       (clk_o),
      .rst_o       (rst_o),
      .ena_o       (ena_o),
      .pha_o       (pha_o)
   );

   // One slave per bus
   ack_responder iwb_slv (sys_clk_i, sys_rst_i, hold_ack, iwb_stb_o, iwb_ack_i);
   ack_responder dwb_slv (sys_clk_i, sys_rst_i, hold_ack, dwb_stb_o, dwb_ack_i);
   ack_responder cwb_slv (sys_clk_i, sys_rst_i, hold_ack, cwb_stb_o, cwb_ack_i);

   // 8 ns board clock
   always #4 sys_clk_i = ~sys_clk_i;

   task automatic abort(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // Core clock follows the board clock
   always @(sys_clk_i) begin
      #1;
      check("clk_o", clk_o, sys_clk_i);
   end

   // Reference for enable, ready and phase from pre-edge values
   always @(posedge sys_clk_i) begin
      ena_ref = !((iwb_stb_o ^ iwb_ack_i) | (dwb_stb_o ^ dwb_ack_i) | (cwb_stb_o ^ cwb_ack_i));
      if (mon_on) begin
         check("pha_o", pha_o, pha_exp);
         check("ena_o", ena_o, ena_ref);
         check("op_ready_o", op_ready_o, !rst_o && ena_ref && !dwb_stb_o && !cwb_stb_o);
      end
      pha_exp = sys_rst_i ? 1'b1 : (pha_exp ^ ena_ref);
      mon_on  = 1'b1;
   end

   // Illegal opcodes by octal group
   // Size 3 load/store, stray group 3 and group 2 beyond MUL and BSF
   function automatic logic ill_rule(input logic [5:0] o);
      logic [2:0] grp;
      logic [2:0] low;
      grp = o[5:3];
      low = o[2:0];
      case (grp)
         3'o2: return (low > 3'd1);
         3'o3: return (low != 3'd3);
         3'o6, 3'o7: return (low[1:0] == 2'd3);
         default: return 1'b0;
      endcase
   endfunction

   // Present an op and return on the edge that accepts it
   task automatic issue(input logic [5:0] opc, input logic [4:0] ra, input logic [15:0] imm);
      int n;
      n = 0;
      op_valid_i <= 1'b1;
      op_opc_i   <= opc;
      op_ra_i    <= ra;
      op_imm_i   <= imm;
      do begin
         @(posedge sys_clk_i);
         n++;
         if (n > TMO) abort("timeout waiting for op_ready_o");
      end while (!op_ready_o);
      op_valid_i <= 1'b0;
   endtask

   // Status register write with readback checked once it lands
   task automatic write_msr(input logic [3:0] v);
      cfg_we_i    <= 1'b1;
      cfg_wdata_i <= v;
      @(posedge sys_clk_i);
      cfg_we_i    <= 1'b0;
      @(posedge sys_clk_i);
      lock_exp = v[MSR_BE];
      check("cfg_rdata_o[3:0]", cfg_rdata_o[3:0], {1'b0, v[2:0]});
   endtask

   task automatic pulse_int();
      sys_int_i <= 1'b1;
      @(posedge sys_clk_i);
      sys_int_i <= 1'b0;
      @(posedge sys_clk_i);
   endtask

   // One data or FSL op with its strobe followed to the ack
   task automatic data_op(input logic [5:0] opc, input logic [15:0] imm, input logic fsl,
                          input logic wre);
      int n;
      n = 0;
      issue(opc, 5'd0, imm);
      @(posedge sys_clk_i);
      while (fsl ? cwb_stb_o : dwb_stb_o) begin
         check(fsl ? "cwb_wre_o" : "dwb_wre_o", fsl ? cwb_wre_o : dwb_wre_o, wre);
         check(fsl ? "dwb_stb_o" : "cwb_stb_o", fsl ? dwb_stb_o : cwb_stb_o, 1'b0);
         check("dwb_cyc_o", dwb_cyc_o, !fsl || lock_exp);
         n++;
         if (n > TMO) abort("timeout waiting for the bus ack to clear the strobe");
         @(posedge sys_clk_i);
      end
      // Never raised at all
      if (n == 0) abort("no strobe after an accepted bus operation");
      // Exactly one strobe and the cycle falls back to the lock bit
      @(posedge sys_clk_i);
      check("dwb_stb_o", dwb_stb_o, 1'b0);
      check("cwb_stb_o", cwb_stb_o, 1'b0);
      check("dwb_cyc_o", dwb_cyc_o, lock_exp);
   endtask

   task automatic reset_release();
      repeat (3) @(posedge sys_clk_i);
      check("rst_o", rst_o, 1'b1);
      check("op_ready_o", op_ready_o, 1'b0);
      sys_rst_i <= 1'b0;
      @(posedge sys_clk_i);
      check("rst_o", rst_o, 1'b1);
      // Phase low after the first release edge
      @(posedge sys_clk_i);
      check("rst_o", rst_o, 1'b1);
      check("pha_o", pha_o, 1'b0);
      // After edge 2
      @(posedge sys_clk_i);
      check("rst_o", rst_o, 1'b0);
      check("iwb_stb_o", iwb_stb_o, 1'b0);
      check("dwb_stb_o", dwb_stb_o, 1'b0);
      check("cwb_stb_o", cwb_stb_o, 1'b0);
      check("int_o", int_o, 1'b0);
      check("xce_o", xce_o, 1'b0);
   endtask

   task automatic load_store_ops();
      logic [5:0] opc;
      logic       st;
      for (int i = 0; i < 8; i++) begin
         // Bus lock on for the second half
         if (i == 4) write_msr(4'(1 << MSR_BE));
         st  = 1'($urandom);
         opc = {2'b11, 1'($urandom), st, 2'($urandom % 3)};
         data_op(opc, 16'($urandom), 1'b0, st);
      end
      write_msr(4'h0);
   endtask

   task automatic fsl_get_put();
      logic [15:0] imm;
      for (int i = 0; i < 6; i++) begin
         imm = 16'($urandom);
         data_op(6'o33, imm, 1'b1, imm[15]);
      end
   endtask

   task automatic interrupt_ack();
      write_msr(4'(1 << MSR_IE));
      pulse_int();
      check("int_o", int_o, 1'b1);
      check("cfg_rdata_o[STAT_INT]", cfg_rdata_o[STAT_INT], 1'b1);
      issue(BRUI, RA_INTACK, 16'h0);
      @(posedge sys_clk_i);
      check("int_o", int_o, 1'b0);
      // Masked by ie clear
      write_msr(4'h0);
      pulse_int();
      check("int_o", int_o, 1'b0);
      // Masked by break in progress
      write_msr(4'((1 << MSR_IE) | (1 << MSR_BIP)));
      pulse_int();
      check("int_o", int_o, 1'b0);
      write_msr(4'h0);
   endtask

   task automatic illegal_opcodes();
      logic [5:0] opc;
      logic       ill;
      for (int o = 0; o < 64; o++) begin
         opc = 6'(o);
         ill = ill_rule(opc);
         // Legal bus ops have their own tests
         if (ill || !((opc[5:4] == 2'b11) || (opc == 6'o33))) begin
            issue(opc, 5'd0, 16'h0);
            @(posedge sys_clk_i);
            check("xce_o", xce_o, ill);
            check("cfg_rdata_o[STAT_XCE]", cfg_rdata_o[STAT_XCE], ill);
            check("dwb_stb_o", dwb_stb_o, 1'b0);
            check("cwb_stb_o", cwb_stb_o, 1'b0);
            if (ill) begin
               issue(BRUI, RA_XCEACK, 16'h0);
               @(posedge sys_clk_i);
               check("xce_o", xce_o, 1'b0);
            end
         end
      end
   endtask

   task automatic fetch_backpressure();
      int   n;
      logic p;
      n = 0;
      hold_ack <= 1'b1;
      // Wait for a fetch left without its ack
      do begin
         @(posedge sys_clk_i);
         n++;
         if (n > TMO) abort("timeout waiting for an open fetch strobe");
      end while (!(iwb_stb_o && !iwb_ack_i));
      p = pha_o;
      repeat (5) begin
         check("ena_o", ena_o, 1'b0);
         check("op_ready_o", op_ready_o, 1'b0);
         check("pha_o", pha_o, p);
         @(posedge sys_clk_i);
      end
      hold_ack <= 1'b0;
      // Each ack clears the fetch and the next edge raises it again
      for (int k = 0; k < 4; k++) begin
         n = 0;
         do begin
            @(posedge sys_clk_i);
            n++;
            if (n > TMO) abort("timeout waiting for iwb_ack_i");
         end while (!(iwb_stb_o && iwb_ack_i));
         @(posedge sys_clk_i);
         check("iwb_stb_o", iwb_stb_o, 1'b0);
         @(posedge sys_clk_i);
         check("iwb_stb_o", iwb_stb_o, 1'b1);
      end
   endtask

   initial begin
      void'($urandom(32'hc6fe601a));
      sys_clk_i   = 1'b0;
      sys_rst_i   = 1'b1;
      sys_int_i   = 1'b0;
      op_valid_i  = 1'b0;
      op_opc_i    = 6'h0;
      op_ra_i     = 5'h0;
      op_imm_i    = 16'h0;
      cfg_we_i    = 1'b0;
      cfg_wdata_i = 4'h0;
      hold_ack    = 1'b0;
      lock_exp    = 1'b0;
      pha_exp     = 1'b1;
      mon_on      = 1'b0;
      reset_release();
      load_store_ops();
      fsl_get_put();
      interrupt_ack();
      illegal_opcodes();
      fetch_backpressure();
      // Any failed bound assertion fails the run
      if (dut0.u_strobe.chk0.fail_cnt != 0) begin
         abort("a bound assertion failed during the run");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/aemb_pkg.sv
verilog/aemb_if.sv
verilog/aemb_decode.sv
verilog/aemb_sysc_ctrl.sv
verilog/aemb_msr_regs.sv
verilog/aemb_intr.sv
verilog/aemb_bus_strobe.sv
verilog/aemb_sysc_top.sv
sim/aemb_sysc_checker.sv
sim/aemb_tb.sv
